/* verilog.f */
hdl/cache_cfg_pkg.sv
hdl/mem_op_pkg.sv
hdl/dcache_ifs.sv
hdl/dcache_arrays.sv
hdl/dcache_pipeline.sv
hdl/dcache_miss_unit.sv
hdl/dcache_top.sv
test/dcache_assertions.sv
test/tb_dcache.sv

/* Makefile */
TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o sim_dcache
	./obj_dir/sim_dcache | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* test/tb_dcache.sv */
/*
 * data cache testbench
 * random core traffic against a byte model of memory,
 * with an AXI memory slave and write-back checks
 */
`timescale 1ns/1ps

module tb_dcache
  import cache_cfg_pkg::*;
  import mem_op_pkg::*;
();

  localparam int TIMEOUT = 5000;

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  logic        req_ready_o;
  op_e         req_op_i;
  size_e       req_size_i;
  logic [31:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic [31:0] rsp_rdata_o;
  logic        rsp_ale_o;
  logic        m_ar_valid_o;
  logic        m_ar_ready_i;
  logic [31:0] m_ar_addr_o;
  logic        m_r_valid_i;
  logic        m_r_ready_o;
  logic [31:0] m_r_data_i;
  logic        m_r_last_i;
  logic        m_aw_valid_o;
  logic        m_aw_ready_i;
  logic [31:0] m_aw_addr_o;
  logic        m_w_valid_o;
  logic        m_w_ready_i;
  logic [31:0] m_w_data_o;
  logic        m_w_last_o;

  integer      seed = 87750;
  int          errors = 0;
  int          checks = 0;
  int          err0;
  int          chk0;
  int          rsp_pct;
  int          axi_pct;
  int          wb_count = 0;
  int          wb0;
  int          sidx;

  // architectural memory and the memory behind the AXI slave
  logic [7:0]  arch_mem [1024];
  logic [7:0]  main_mem [1024];
  logic [63:0] dirty_lines;
  core_rsp_t   exp_q [$];
  core_rsp_t   rsp_exp;
  core_rsp_t   rsp_got;

  logic        first_ar_pending;
  cache_addr_u first_ar_exp;
  logic        r_active;
  logic [1:0]  r_beat;
  cache_addr_u ar_base;
  cache_addr_u aw_base;
  logic [1:0]  w_beat;
  line_t       w_line;
  line_t       exp_line;

  dcache_top dut0 (.*);

  bind dcache_top dcache_assertions u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .miss_active_i (miss_bus.start || miss_bus.busy),
    .m_ar_valid_o  (m_ar_valid_o),
    .m_ar_ready_i  (m_ar_ready_i),
    .m_ar_addr_o   (m_ar_addr_o),
    .m_aw_valid_o  (m_aw_valid_o),
    .m_aw_ready_i  (m_aw_ready_i),
    .m_aw_addr_o   (m_aw_addr_o),
    .m_w_valid_o   (m_w_valid_o),
    .m_w_ready_i   (m_w_ready_i),
    .m_w_data_o    (m_w_data_o),
    .m_w_last_o    (m_w_last_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [7:0] fill_byte(input logic [9:0] a);
    return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5a;
  endfunction

  // ========================================
  // checks
  // ========================================
  task automatic abort(input string why);
    $display("ERROR t=%0t %s", $time, why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_rsp(input core_rsp_t got, input core_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t rsp_rdata_o/rsp_ale_o @%h got %h/%b exp %h/%b",
               $time, exp.addr, got.rdata, got.ale, exp.rdata, exp.ale);
    end
  endtask

  task automatic check_addr(input string name, input cache_addr_u got, input cache_addr_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got.addr, exp.addr);
    end
  endtask

  task automatic check_line(input cache_addr_u a, input line_t got, input line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t m_w_data_o line %h got %h exp %h", $time, a.addr, got, exp);
    end
  endtask

  // ========================================
  // reference model and request driver
  // ========================================
  task automatic expect_access(input op_e op, input size_e size, input logic [31:0] addr,
                               input logic [31:0] wdata);
    core_rsp_t   e;
    int          n;
    logic [31:0] v;
    n = (size == W) ? 4 : (size == H || size == HU) ? 2 : 1;
    e.op    = op;
    e.addr  = addr;
    e.ale   = (addr & 32'(n - 1)) != 0;
    e.rdata = '0;
    if (!e.ale) begin
      if (op == STORE) begin
        for (int i = 0; i < n; i++)
          arch_mem[addr[9:0] + 10'(i)] = wdata[8*i +: 8];
        dirty_lines[addr[9:4]] = 1'b1;
      end else begin
        v = '0;
        for (int i = 0; i < n; i++)
          v[8*i +: 8] = arch_mem[addr[9:0] + 10'(i)];
        if (size == B)
          v = {{24{v[7]}}, v[7:0]};
        else if (size == H)
          v = {{16{v[15]}}, v[15:0]};
        e.rdata = v;
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic issue(input op_e op, input size_e size, input logic [31:0] addr,
                       input logic [31:0] wdata);
    int cnt;
    @(posedge clk);
    #1;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_size_i  = size;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    cnt = 0;
    @(negedge clk);
    while (!req_ready_o) begin
      cnt++;
      if (cnt > TIMEOUT)
        abort("req_ready_o stayed low");
      @(negedge clk);
    end
    expect_access(op, size, addr, wdata);
  endtask

  task automatic random_access(input int store_pct, input logic misalign, input int window);
    op_e         op;
    size_e       size;
    logic [31:0] addr;
    op   = (rnd(100) < store_pct) ? STORE : LOAD;
    size = size_e'(3'(rnd(5)));
    addr = 32'(rnd(window));
    if (!misalign) begin
      if (size == W)
        addr[1:0] = 2'b00;
      else if (size == H || size == HU)
        addr[0] = 1'b0;
    end
    issue(op, size, addr, $random(seed));
  endtask

  task automatic drain();
    int cnt;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
    cnt = 0;
    while (exp_q.size() != 0 || r_active) begin
      cnt++;
      if (cnt > TIMEOUT)
        abort("responses still outstanding");
      @(negedge clk);
    end
  endtask

  task automatic begin_test();
    err0 = errors;
    chk0 = checks;
  endtask

  task automatic end_test(input string name);
    $display("test %-16s checks %0d errors %0d", name, checks - chk0, errors - err0);
  endtask

  // ========================================
  // response monitor and AXI memory slave
  // ========================================
  always @(negedge clk) begin
    if (rst_n && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR t=%0t response with no request outstanding", $time);
      end else begin
        rsp_exp       = exp_q.pop_front();
        rsp_got       = rsp_exp;
        rsp_got.rdata = rsp_rdata_o;
        rsp_got.ale   = rsp_ale_o;
        check_rsp(rsp_got, rsp_exp);
      end
    end
  end

  // handshakes seen mid-cycle take effect at the next edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (m_r_valid_i && m_r_ready_o) begin
        if (r_beat == 2'd3)
          r_active = 1'b0;
        r_beat = r_beat + 2'd1;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        ar_base.addr = m_ar_addr_o;
        r_active     = 1'b1;
        r_beat       = 2'd0;
        check_bit("m_ar_addr_o[3:0] nonzero", |m_ar_addr_o[3:0], 1'b0);
        if (first_ar_pending) begin
          check_addr("m_ar_addr_o", ar_base, first_ar_exp);
          first_ar_pending = 1'b0;
        end
      end
      if (m_aw_valid_o && m_aw_ready_i) begin
        aw_base.addr = m_aw_addr_o;
        w_beat       = 2'd0;
      end
      if (m_w_valid_o && m_w_ready_i) begin
        check_bit("m_w_last_o", m_w_last_o, w_beat == 2'd3);
        w_line[w_beat] = m_w_data_o;
        for (int i = 0; i < 4; i++)
          main_mem[{aw_base.addr[9:4], w_beat, 2'(i)}] = m_w_data_o[8*i +: 8];
        if (w_beat == 2'd3) begin
          for (int i = 0; i < 16; i++)
            exp_line[i/4][8*(i%4) +: 8] = arch_mem[{aw_base.addr[9:4], 4'(i)}];
          check_line(aw_base, w_line, exp_line);
          check_bit("dirty line written back", dirty_lines[aw_base.addr[9:4]], 1'b1);
          dirty_lines[aw_base.addr[9:4]] = 1'b0;
          wb_count++;
        end
        w_beat = w_beat + 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    rsp_ready_i  = rnd(100) < rsp_pct;
    m_ar_ready_i = rnd(100) < axi_pct;
    m_aw_ready_i = rnd(100) < axi_pct;
    m_w_ready_i  = rnd(100) < axi_pct;
    m_r_valid_i  = r_active && (rnd(100) < axi_pct);
    for (int i = 0; i < 4; i++)
      m_r_data_i[8*i +: 8] = main_mem[{ar_base.addr[9:4], r_beat, 2'(i)}];
    m_r_last_i = r_beat == 2'd3;
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    rst_n            = 1'b0;
    req_valid_i      = 1'b0;
    req_op_i         = LOAD;
    req_size_i       = W;
    req_addr_i       = '0;
    req_wdata_i      = '0;
    rsp_ready_i      = 1'b0;
    m_ar_ready_i     = 1'b0;
    m_aw_ready_i     = 1'b0;
    m_w_ready_i      = 1'b0;
    m_r_valid_i      = 1'b0;
    m_r_data_i       = '0;
    m_r_last_i       = 1'b0;
    rsp_pct          = 80;
    axi_pct          = 60;
    r_active         = 1'b0;
    r_beat           = '0;
    w_beat           = '0;
    ar_base          = '0;
    aw_base          = '0;
    dirty_lines      = '0;
    first_ar_pending = 1'b0;
    first_ar_exp     = '0;
    for (int a = 0; a < 1024; a++) begin
      arch_mem[a] = fill_byte(10'(a));
      main_mem[a] = fill_byte(10'(a));
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    begin_test();
    @(negedge clk);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("m_ar_valid_o", m_ar_valid_o, 1'b0);
    check_bit("m_aw_valid_o", m_aw_valid_o, 1'b0);
    check_bit("m_w_valid_o", m_w_valid_o, 1'b0);
    check_bit("m_r_ready_o", m_r_ready_o, 1'b0);
    first_ar_pending  = 1'b1;
    first_ar_exp.addr = 32'h0000_0134;
    first_ar_exp.f.word = '0;
    first_ar_exp.f.ofs  = '0;
    issue(LOAD, W, 32'h0000_0134, '0);
    drain();
    check_bit("first load read burst seen", first_ar_pending, 1'b0);
    end_test("reset");

    begin_test();
    repeat (200) random_access(0, 1'b0, 512);
    drain();
    end_test("load format");

    // store then load of the same line, back to back
    begin_test();
    for (int k = 0; k < 100; k++) begin
      random_access(100, 1'b0, 512);
      issue(LOAD, size_e'(3'(rnd(5))), {req_addr_i[31:4], 2'(rnd(4)), 2'b00},
            $random(seed));
    end
    drain();
    end_test("store load");

    begin_test();
    sidx = rnd(16);
    issue(LOAD, W, 32'(512 + ((sidx + 1) % 16) * 16), '0);
    issue(LOAD, W, 32'(768 + ((sidx + 1) % 16) * 16), '0);
    drain();
    wb0 = wb_count;
    for (int k = 0; k < 3; k++)
      issue(LOAD, W, 32'(k * 256 + ((sidx + 1) % 16) * 16), '0);
    drain();
    check_bit("clean eviction without write burst", wb_count == wb0, 1'b1);
    for (int k = 0; k < 4; k++)
      issue(STORE, W, 32'(k * 256 + sidx * 16 + rnd(4) * 4), $random(seed));
    for (int k = 0; k < 4; k++)
      issue(LOAD, W, 32'(k * 256 + sidx * 16), '0);
    drain();
    check_bit("dirty eviction wrote back", wb_count > wb0, 1'b1);
    end_test("dirty eviction");

    begin_test();
    for (int k = 0; k < 60; k++) begin
      issue(rnd(2) == 0 ? LOAD : STORE, (k % 3 == 0) ? W : (k % 3 == 1) ? H : HU,
            32'(rnd(128) * 4 + 1 + 2 * (k % 2)), $random(seed));
      random_access(0, 1'b0, 512);
    end
    drain();
    end_test("misalign");

    begin_test();
    rsp_pct = 30;
    repeat (300) random_access(40, 1'b1, 512);
    drain();
    end_test("back pressure");

    $display("summary: checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* test/dcache_assertions.sv */
/*
 * data cache handshake assertions
 * AXI stability, write burst length and core request stalls
 */
`timescale 1ns/1ps

module dcache_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        req_ready_o,
  input logic        rsp_valid_o,
  input logic        miss_active_i,
  input logic        m_ar_valid_o,
  input logic        m_ar_ready_i,
  input logic [31:0] m_ar_addr_o,
  input logic        m_aw_valid_o,
  input logic        m_aw_ready_i,
  input logic [31:0] m_aw_addr_o,
  input logic        m_w_valid_o,
  input logic        m_w_ready_i,
  input logic [31:0] m_w_data_o,
  input logic        m_w_last_o
);

  logic [1:0] w_cnt;

  // beats of the current write burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      w_cnt <= '0;
    else if (m_w_valid_o && m_w_ready_i)
      w_cnt <= w_cnt + 2'd1;
  end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_addr_o))
    else $error("ar payload changed before accept");

  aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_addr_o))
    else $error("aw payload changed before accept");

  w_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_w_valid_o && !m_w_ready_i |=> m_w_valid_o && $stable(m_w_data_o))
    else $error("w payload changed before accept");

  w_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
    m_w_valid_o |-> (m_w_last_o == (w_cnt == 2'd3)))
    else $error("wlast not on the fourth beat");

  req_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !req_ready_o |-> rsp_valid_o || miss_active_i)
    else $error("request stalled without a reason");

endmodule

/* hdl/dcache_top.sv */
/*
 * L1 data cache top level
 * 2-way write-back cache with a core request port and an AXI master
 */
`timescale 1ns/1ps

module dcache_top
  import mem_op_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // core request
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  op_e         req_op_i,
  input  size_e       req_size_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_wdata_i,
  // core response
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output logic [31:0] rsp_rdata_o,
  output logic        rsp_ale_o,
  // AXI read
  output logic        m_ar_valid_o,
  input  logic        m_ar_ready_i,
  output logic [31:0] m_ar_addr_o,
  input  logic        m_r_valid_i,
  output logic        m_r_ready_o,
  input  logic [31:0] m_r_data_i,
  input  logic        m_r_last_i,
  // AXI write
  output logic        m_aw_valid_o,
  input  logic        m_aw_ready_i,
  output logic [31:0] m_aw_addr_o,
  output logic        m_w_valid_o,
  input  logic        m_w_ready_i,
  output logic [31:0] m_w_data_o,
  output logic        m_w_last_o
);

  cache_array_if arr_bus ();
  miss_if        miss_bus ();

  dcache_pipeline u_pipeline (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_size_i  (req_size_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_ale_o   (rsp_ale_o),
    .arr         (arr_bus.pipe),
    .mreq        (miss_bus.pipe)
  );

  dcache_arrays u_arrays (
    .clk   (clk),
    .rst_n (rst_n),
    .arr   (arr_bus.store)
  );

  dcache_miss_unit u_miss (
    .clk          (clk),
    .rst_n        (rst_n),
    .mreq         (miss_bus.miss),
    .arr          (arr_bus.miss),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .m_r_data_i   (m_r_data_i),
    .m_r_last_i   (m_r_last_i),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_aw_addr_o  (m_aw_addr_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .m_w_data_o   (m_w_data_o),
    .m_w_last_o   (m_w_last_o)
  );

endmodule

/* hdl/dcache_miss_unit.sv */
/*
 * data cache miss unit
 * writes back a dirty victim, then refills the line over AXI,
 * four-beat bursts of 32-bit words
 */
`timescale 1ns/1ps

module dcache_miss_unit
  import cache_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  miss_if.miss        mreq,
  cache_array_if.miss arr,
  output logic        m_ar_valid_o,
  input  logic        m_ar_ready_i,
  output logic [31:0] m_ar_addr_o,
  input  logic        m_r_valid_i,
  output logic        m_r_ready_o,
  input  logic [31:0] m_r_data_i,
  input  logic        m_r_last_i,
  output logic        m_aw_valid_o,
  input  logic        m_aw_ready_i,
  output logic [31:0] m_aw_addr_o,
  output logic        m_w_valid_o,
  input  logic        m_w_ready_i,
  output logic [31:0] m_w_data_o,
  output logic        m_w_last_o
);

  localparam logic [WORD_W-1:0] LAST_BEAT = WORD_W'(WORDS_PER_LINE - 1);

  typedef enum logic [2:0] {
    IDLE,
    MISS,
    WRITE_BACK,
    LOOKUP,
    REFILL
  } state_e;

  state_e                          state;
  logic [WORD_W-1:0]               beat;
  cache_addr_u                     line_addr;
  way_t                            v_way;
  logic [TAG_W-1:0]                v_tag;
  logic                            v_dirty;
  line_t                           v_line;
  logic [WORDS_PER_LINE-2:0][31:0] rbuf;
  logic                            fill;

  // last read beat completes the line
  assign fill = state == REFILL && m_r_valid_i && m_r_last_i;

  // ========================================
  // state machine and beat counter
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      beat  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (mreq.start)
            state <= MISS;
        end
        MISS: begin
          if (!v_dirty)
            state <= LOOKUP;
          else if (m_aw_ready_i)
            state <= WRITE_BACK;
        end
        WRITE_BACK: begin
          if (m_w_ready_i && beat == LAST_BEAT)
            state <= LOOKUP;
        end
        LOOKUP: begin
          if (m_ar_ready_i)
            state <= REFILL;
        end
        REFILL: begin
          if (fill)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase

      if (state == IDLE)
        beat <= '0;
      else if ((state == WRITE_BACK && m_w_ready_i) || (state == REFILL && m_r_valid_i))
        beat <= beat + 1'b1;
    end
  end

  // victim snapshot at start, refill words as they arrive
  always_ff @(posedge clk) begin
    if (state == IDLE && mreq.start) begin
      line_addr <= mreq.addr;
      v_way     <= mreq.victim_way;
      v_tag     <= mreq.victim_tag;
      v_dirty   <= mreq.victim_dirty;
      v_line    <= arr.rd_line[mreq.victim_way];
    end
    if (state == REFILL && m_r_valid_i && beat != LAST_BEAT)
      rbuf[beat] <= m_r_data_i;
  end

  assign mreq.busy = state != IDLE;
  assign mreq.done = fill;

  // ========================================
  // AXI master
  // ========================================
  assign m_aw_valid_o = state == MISS && v_dirty;
  assign m_aw_addr_o  = {v_tag, line_addr.f.idx, {(WORD_W + OFS_W){1'b0}}};
  assign m_w_valid_o  = state == WRITE_BACK;
  assign m_w_data_o   = v_line[beat];
  assign m_w_last_o   = m_w_valid_o && beat == LAST_BEAT;

  assign m_ar_valid_o = state == LOOKUP;
  assign m_ar_addr_o  = {line_addr.f.tag, line_addr.f.idx, {(WORD_W + OFS_W){1'b0}}};
  assign m_r_ready_o  = state == REFILL;

  // new line lands clean in the victim way
  assign arr.rf_we   = fill;
  assign arr.rf_way  = v_way;
  assign arr.rf_idx  = line_addr.f.idx;
  assign arr.rf_tag  = line_addr.f.tag;
  assign arr.rf_line = {m_r_data_i, rbuf};
  assign arr.rf_meta = '{valid: 1'b1, dirty: 1'b0};

endmodule

/* hdl/dcache_pipeline.sv */
/*
 * data cache lookup pipeline
 * stage 0 checks alignment and reads the arrays, stage 1 compares tags
 * and starts misses, stage 2 formats loads, merges stores and responds
 */
`timescale 1ns/1ps

module dcache_pipeline
  import cache_cfg_pkg::*;
  import mem_op_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  op_e         req_op_i,
  input  size_e       req_size_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_wdata_i,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output logic [31:0] rsp_rdata_o,
  output logic        rsp_ale_o,
  cache_array_if.pipe arr,
  miss_if.pipe        mreq
);

  core_req_t   req_in;
  cache_addr_u req_addr;
  logic        req_ale;

  logic        s1_valid;
  logic        s1_ready;
  logic        s1_go;
  logic        s1_wait;
  logic        s1_ale;
  logic        s1_hit;
  core_req_t   s1_req;
  cache_addr_u s1_addr;
  way_t        hit_way;
  way_t        victim;
  line_t       s1_line;

  logic        s2_valid;
  logic        s2_ready;
  logic        s2_ale;
  core_req_t   s2_req;
  cache_addr_u s2_addr;
  way_t        s2_way;
  line_t       s2_line;
  line_t       merged;
  logic        st_we;
  logic [31:0] s2_word;
  logic [7:0]  byte_v;
  logic [15:0] half_v;
  logic [31:0] load_v;
  core_rsp_t   rsp;

  // ========================================
  // stage 0: accept, alignment, array read
  // ========================================
  assign req_in = '{op: req_op_i, size: req_size_i, addr: req_addr_i, wdata: req_wdata_i};
  assign req_addr.addr = req_addr_i;

  always_comb begin
    case (req_size_i)
      H, HU:   req_ale = req_addr_i[0];
      W:       req_ale = |req_addr_i[1:0];
      default: req_ale = 1'b0;
    endcase
  end

  assign req_ready_o = s1_ready;
  // a held stage 1 keeps re-reading its own set
  assign arr.rd_idx = s1_ready ? req_addr.f.idx : s1_addr.f.idx;

  // ========================================
  // stage 1: tag compare, lru, miss start
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_wait  <= 1'b0;
    end else begin
      if (s1_ready)
        s1_valid <= req_valid_i;
      if (mreq.start)
        s1_wait <= 1'b1;
      else if (mreq.done)
        s1_wait <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_req <= req_in;
      s1_ale <= req_ale;
    end
  end

  assign s1_addr.addr = s1_req.addr;

  always_comb begin
    s1_hit  = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (arr.rd_meta[w].valid && arr.rd_tag[w] == s1_addr.f.tag) begin
        s1_hit  = 1'b1;
        hit_way = way_t'(w);
      end
    end
    // the array read missed a store retiring in stage 2 right now
    s1_line = arr.rd_line[hit_way];
    if (st_we && s2_addr.f.idx == s1_addr.f.idx && s2_way == hit_way)
      s1_line = merged;
  end

  assign victim   = arr.rd_lru;
  assign s1_go    = s1_valid && (s1_ale || s1_hit) && s2_ready;
  assign s1_ready = !s1_valid || s1_go;

  // start only with stage 2 drained so the victim data is current
  assign mreq.start        = s1_valid && !s1_ale && !s1_hit && !s2_valid && !s1_wait;
  assign mreq.addr         = s1_addr;
  assign mreq.victim_way   = victim;
  assign mreq.victim_tag   = arr.rd_tag[victim];
  assign mreq.victim_dirty = arr.rd_meta[victim].valid && arr.rd_meta[victim].dirty;

  assign arr.lru_we  = s1_go && !s1_ale;
  assign arr.lru_idx = s1_addr.f.idx;
  assign arr.lru_val = ~hit_way;

  // ========================================
  // stage 2: format, merge, respond
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      s2_valid <= 1'b0;
    else if (s2_ready)
      s2_valid <= s1_go;
  end

  always_ff @(posedge clk) begin
    if (s1_go) begin
      s2_req  <= s1_req;
      s2_ale  <= s1_ale;
      s2_way  <= hit_way;
      s2_line <= s1_line;
    end
  end

  assign s2_addr.addr = s2_req.addr;
  assign s2_ready     = !s2_valid || (rsp_ready_i && !mreq.busy);
  assign st_we        = s2_valid && rsp_ready_i && !mreq.busy && s2_req.op == STORE && !s2_ale;

  always_comb begin
    s2_word = s2_line[s2_addr.f.word];
    byte_v  = s2_word[{s2_addr.f.ofs, 3'b000} +: 8];
    half_v  = s2_word[{s2_addr.f.ofs[1], 4'b0000} +: 16];
    merged  = s2_line;
    case (s2_req.size)
      B, BU: begin
        load_v = (s2_req.size == B) ? {{24{byte_v[7]}}, byte_v} : {24'b0, byte_v};
        merged[s2_addr.f.word][{s2_addr.f.ofs, 3'b000} +: 8] = s2_req.wdata[7:0];
      end
      H, HU: begin
        load_v = (s2_req.size == H) ? {{16{half_v[15]}}, half_v} : {16'b0, half_v};
        merged[s2_addr.f.word][{s2_addr.f.ofs[1], 4'b0000} +: 16] = s2_req.wdata[15:0];
      end
      default: begin
        load_v = s2_word;
        merged[s2_addr.f.word] = s2_req.wdata;
      end
    endcase
  end

  assign arr.st_we   = st_we;
  assign arr.st_way  = s2_way;
  assign arr.st_idx  = s2_addr.f.idx;
  assign arr.st_line = merged;
  assign arr.st_meta = '{valid: 1'b1, dirty: 1'b1};

  always_comb begin
    rsp.op    = s2_req.op;
    rsp.addr  = s2_req.addr;
    rsp.ale   = s2_ale;
    rsp.rdata = (s2_ale || s2_req.op == STORE) ? '0 : load_v;
  end

  assign rsp_valid_o = s2_valid;
  assign rsp_rdata_o = rsp.rdata;
  assign rsp_ale_o   = rsp.ale;

endmodule

/* hdl/dcache_arrays.sv */
/*
 * data cache storage
 * tag, meta and line per way and set, one lru bit per set,
 * registered read with write-first forwarding
 */
`timescale 1ns/1ps

module dcache_arrays
  import cache_cfg_pkg::*;
(
  input logic          clk,
  input logic          rst_n,
  cache_array_if.store arr
);

  logic [TAG_W-1:0]           tag_mem  [WAYS][SETS];
  line_t                      line_mem [WAYS][SETS];
  meta_t [WAYS-1:0][SETS-1:0] meta_mem;
  logic [SETS-1:0]            lru_mem;

  logic [WAYS-1:0][TAG_W-1:0] tag_nx;
  meta_t [WAYS-1:0]           meta_nx;
  line_t [WAYS-1:0]           line_nx;
  way_t                       lru_nx;

  // read set, overridden by a write landing in it this cycle
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      tag_nx[w]  = tag_mem[w][arr.rd_idx];
      meta_nx[w] = meta_mem[w][arr.rd_idx];
      line_nx[w] = line_mem[w][arr.rd_idx];
      if (arr.st_we && arr.st_way == way_t'(w) && arr.st_idx == arr.rd_idx) begin
        meta_nx[w] = arr.st_meta;
        line_nx[w] = arr.st_line;
      end
      if (arr.rf_we && arr.rf_way == way_t'(w) && arr.rf_idx == arr.rd_idx) begin
        tag_nx[w]  = arr.rf_tag;
        meta_nx[w] = arr.rf_meta;
        line_nx[w] = arr.rf_line;
      end
    end
    lru_nx = lru_mem[arr.rd_idx];
    if (arr.lru_we && arr.lru_idx == arr.rd_idx)
      lru_nx = arr.lru_val;
  end

  always_ff @(posedge clk) begin
    if (arr.st_we)
      line_mem[arr.st_way][arr.st_idx] <= arr.st_line;
    if (arr.rf_we) begin
      tag_mem[arr.rf_way][arr.rf_idx]  <= arr.rf_tag;
      line_mem[arr.rf_way][arr.rf_idx] <= arr.rf_line;
    end
    arr.rd_tag  <= tag_nx;
    arr.rd_line <= line_nx;
  end

  // valid bits and lru start cleared
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_mem    <= '0;
      lru_mem     <= '0;
      arr.rd_meta <= '0;
      arr.rd_lru  <= '0;
    end else begin
      if (arr.st_we)
        meta_mem[arr.st_way][arr.st_idx] <= arr.st_meta;
      if (arr.rf_we)
        meta_mem[arr.rf_way][arr.rf_idx] <= arr.rf_meta;
      if (arr.lru_we)
        lru_mem[arr.lru_idx] <= arr.lru_val;
      arr.rd_meta <= meta_nx;
      arr.rd_lru  <= lru_nx;
    end
  end

endmodule

/* hdl/dcache_ifs.sv */
/*
 * data cache internal interfaces
 * array port shared by the pipeline and the miss unit,
 * and the miss request handshake between them
 */
`timescale 1ns/1ps

interface cache_array_if
  import cache_cfg_pkg::*;
();
  // read port, answers one cycle after rd_idx
  logic [IDX_W-1:0]           rd_idx;
  logic [WAYS-1:0][TAG_W-1:0] rd_tag;
  meta_t [WAYS-1:0]           rd_meta;
  line_t [WAYS-1:0]           rd_line;
  way_t                       rd_lru;

  // store hit write from stage 2
  logic                       st_we;
  way_t                       st_way;
  logic [IDX_W-1:0]           st_idx;
  line_t                      st_line;
  meta_t                      st_meta;

  // lru update from stage 1
  logic                       lru_we;
  logic [IDX_W-1:0]           lru_idx;
  way_t                       lru_val;

  // line fill from the miss unit
  logic                       rf_we;
  way_t                       rf_way;
  logic [IDX_W-1:0]           rf_idx;
  logic [TAG_W-1:0]           rf_tag;
  line_t                      rf_line;
  meta_t                      rf_meta;

  modport pipe (
    output rd_idx, st_we, st_way, st_idx, st_line, st_meta, lru_we, lru_idx, lru_val,
    input  rd_tag, rd_meta, rd_line, rd_lru
  );

  modport miss (
    output rf_we, rf_way, rf_idx, rf_tag, rf_line, rf_meta,
    input  rd_line
  );

  modport store (
    input  rd_idx, st_we, st_way, st_idx, st_line, st_meta, lru_we, lru_idx, lru_val,
    input  rf_we, rf_way, rf_idx, rf_tag, rf_line, rf_meta,
    output rd_tag, rd_meta, rd_line, rd_lru
  );

endinterface

interface miss_if
  import cache_cfg_pkg::*;
();
  logic             start;
  cache_addr_u      addr;
  way_t             victim_way;
  logic [TAG_W-1:0] victim_tag;
  logic             victim_dirty;
  logic             busy;
  logic             done;

  modport pipe (output start, addr, victim_way, victim_tag, victim_dirty, input busy, done);
  modport miss (input start, addr, victim_way, victim_tag, victim_dirty, output busy, done);

endinterface

/* hdl/mem_op_pkg.sv */
/*
 * core memory operations
 * access sizes and the load/store request and response words
 */
package mem_op_pkg;

  // signed and unsigned variants for sub-word loads
  typedef enum logic [2:0] {
    B,
    H,
    W,
    BU,
    HU
  } size_e;

  typedef enum logic {
    LOAD,
    STORE
  } op_e;

  typedef struct packed {
    op_e         op;
    size_e       size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } core_req_t;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        ale;
  } core_rsp_t;

endpackage

/* hdl/cache_cfg_pkg.sv */
/*
 * data cache geometry
 * 2 ways, 16 sets, 16-byte lines of four 32-bit words,
 * plus the address, line and meta types built on it
 */
package cache_cfg_pkg;

  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int WORDS_PER_LINE = 4;

  localparam int TAG_W  = 24;
  localparam int IDX_W  = 4;
  localparam int WORD_W = 2;
  localparam int OFS_W  = 2;

  // one physical address, seen flat or split into cache fields
  typedef union packed {
    logic [31:0] addr;
    struct packed {
      logic [TAG_W-1:0]  tag;
      logic [IDX_W-1:0]  idx;
      logic [WORD_W-1:0] word;
      logic [OFS_W-1:0]  ofs;
    } f;
  } cache_addr_u;

  typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

  typedef logic [0:0] way_t;

endpackage
